/* verilog/system_settings.svh */
// System settings for clock rate, serial rate, internal RAM size and UART address
`ifndef SYSTEM_SETTINGS_SVH
`define SYSTEM_SETTINGS_SVH

// Main clock in Hz
`define CLKSPEED 25000000

// Serial line rate
`define BAUD 115200

// Clocks per serial bit, rounded to nearest
`define BIT_CYCLES ((`CLKSPEED + (`BAUD / 2)) / `BAUD)

// Internal block RAM address width in words
`define RAMSIZE 12

// UART register pair, status at even address and data at odd
`define UART_BASE 16'hfe08

`endif

/* verilog/system_pkg.sv */
// Shared bus types and SRAM phase codes for the processor bus subsystem
package system_pkg;

   // Master request, stable while req is high
   typedef struct packed {
      logic [19:0] address;
      logic        rnw;
      logic [31:0] wdata;
   } bus_req_t;

   // Response, valid while ack is high
   typedef struct packed {
      logic [31:0] rdata;
   } bus_rsp_t;

   // One select per target plus the access strobe
   typedef struct packed {
      logic ram;
      logic uart;
      logic sram;
      logic strobe;
   } target_sel_t;

   // Controller sequence
   typedef enum logic [2:0] {
      IDLE,
      ACCESS,
      WAIT_SRAM,
      WE_PULSE,
      HOLD,
      DONE
   } cycle_state_t;

   // External SRAM access phases
   localparam logic [1:0] SRAM_SETUP = 2'd0;
   localparam logic [1:0] SRAM_PULSE = 2'd1;
   localparam logic [1:0] SRAM_HOLD  = 2'd2;

endpackage

/* verilog/bus_cycle_ctrl.sv */
// Bus cycle controller that decodes each request and sequences the target access
`include "system_settings.svh"

module bus_cycle_ctrl (
   input  logic                    clk,
   input  logic                    reset_b,
   input  logic                    req,
   input  system_pkg::bus_req_t    bus_req,
   input  logic [31:0]             ram_rdata,
   input  logic [15:0]             uart_rdata,
   input  logic [15:0]             sram_rdata,
   output logic                    ack,
   output system_pkg::bus_rsp_t    bus_rsp,
   output system_pkg::target_sel_t sel,
   output system_pkg::bus_req_t    req_q,
   output logic [1:0]              sram_phase
);
   import system_pkg::*;

   cycle_state_t state;
   logic         hit_uart;
   logic         hit_ram;
   logic         ram_q;
   logic         uart_q;
   logic         sram_q;
   logic [31:0]  rdata_mux;

   // UART pair ignores address bit 0
   assign hit_uart = ({bus_req.address[15:1], 1'b0} == `UART_BASE);

   // RAM mirrored at bottom and top of each page
   assign hit_ram = (~|bus_req.address[15:`RAMSIZE]) | (&bus_req.address[15:`RAMSIZE]);

   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         state  <= IDLE;
         ack    <= 1'b0;
         ram_q  <= 1'b0;
         uart_q <= 1'b0;
         sram_q <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE:
               if (req)
               begin
                  // UART wins over the RAM mirror
                  uart_q <= hit_uart;
                  ram_q  <= hit_ram & ~hit_uart;
                  sram_q <= ~hit_ram & ~hit_uart;
                  state  <= ACCESS;
               end
            ACCESS:
               if (sram_q)
                  state <= req_q.rnw ? WAIT_SRAM : WE_PULSE;
               else
                  state <= DONE;
            WAIT_SRAM, WE_PULSE:
               state <= HOLD;
            HOLD:
               state <= DONE;
            DONE:
               if (!ack)
                  ack <= 1'b1;
               else if (!req)
               begin
                  // Master released, close the cycle
                  ack   <= 1'b0;
                  state <= IDLE;
               end
            default:
               state <= IDLE;
         endcase
      end
   end

   // Request held for the whole cycle
   always_ff @(posedge clk)
   begin
      if (state == IDLE && req)
         req_q <= bus_req;
   end

   // Narrow targets zero-extended
   always_comb
   begin
      if (uart_q)
         rdata_mux = {16'h0000, uart_rdata};
      else if (ram_q)
         rdata_mux = ram_rdata;
      else
         rdata_mux = {16'h0000, sram_rdata};
   end

   // Latched once, held while ack is high
   always_ff @(posedge clk)
   begin
      if (state == DONE && !ack)
         bus_rsp.rdata <= rdata_mux;
   end

   // Strobe covers every target phase
   assign sel.ram    = ram_q;
   assign sel.uart   = uart_q;
   assign sel.sram   = sram_q;
   assign sel.strobe = (state == ACCESS) || (state == WAIT_SRAM) ||
                       (state == WE_PULSE) || (state == HOLD);

   always_comb
   begin
      case (state)
         WAIT_SRAM, WE_PULSE: sram_phase = SRAM_PULSE;
         HOLD:                sram_phase = SRAM_HOLD;
         default:             sram_phase = SRAM_SETUP;
      endcase
   end

endmodule

/* verilog/baud_timer.sv */
// Restartable serial bit timer with mid-bit and end-of-bit ticks
`include "system_settings.svh"

module baud_timer (
   input  logic clk,
   input  logic reset_b,
   input  logic restart,
   output logic half_tick,
   output logic bit_tick
);

   localparam int CNT_W = $clog2(`BIT_CYCLES);
   localparam logic [CNT_W-1:0] LAST = CNT_W'(`BIT_CYCLES - 1);
   localparam logic [CNT_W-1:0] HALF = CNT_W'((`BIT_CYCLES / 2) - 1);

   logic [CNT_W-1:0] count;

   always_ff @(posedge clk)
   begin
      if (!reset_b)
         count <= '0;
      else if (restart)
         count <= '0;
      // Wrap at the end of each bit
      else if (count == LAST)
         count <= '0;
      else
         count <= count + 1'b1;
   end

   // Centre of the bit
   assign half_tick = (count == HALF);

   // Last clock of the bit
   assign bit_tick = (count == LAST);

endmodule

/* verilog/block_ram.sv */
// Internal single-port synchronous RAM of 32-bit words
`include "system_settings.svh"

module block_ram (
   input  logic                    clk,
   input  system_pkg::target_sel_t sel,
   input  logic [`RAMSIZE-1:0]     address,
   input  logic                    rnw,
   input  logic [31:0]             wdata,
   output logic [31:0]             rdata
);

   logic [31:0] mem [0:(2**`RAMSIZE)-1];
   logic        access;

   assign access = sel.ram & sel.strobe;

   always_ff @(posedge clk)
   begin
      if (access)
      begin
         if (!rnw)
            mem[address] <= wdata;
         else
            // Word ready the cycle after the strobe
            rdata <= mem[address];
      end
   end

endmodule

/* verilog/uart_port.sv */
// UART with status and data registers and baud-paced transmit and receive shifters
module uart_port (
   input  logic                    clk,
   input  logic                    reset_b,
   input  system_pkg::target_sel_t sel,
   input  logic                    a0,
   input  logic                    rnw,
   input  logic [15:0]             wdata,
   input  logic                    rxd,
   output logic [15:0]             rdata,
   output logic                    txd
);

   logic       rd;
   logic       wr;
   logic       tx_load;
   logic       tx_busy;
   logic [9:0] tx_shift;
   logic [3:0] tx_cnt;
   logic       tx_bit_tick;
   logic [2:0] rxd_sync;
   logic       start_edge;
   logic       rx_restart;
   logic       rx_half_tick;
   logic       rx_busy;
   logic [3:0] rx_bit;
   logic [7:0] rx_shift;
   logic [7:0] rx_data;
   logic       rx_valid;

   assign rd = sel.uart & sel.strobe & rnw;
   assign wr = sel.uart & sel.strobe & ~rnw;

   // Writes while busy are dropped
   assign tx_load = wr & a0 & ~tx_busy;

   baud_timer i_tx_timer (
      .clk       (clk),
      .reset_b   (reset_b),
      .restart   (tx_load),
      .half_tick (),
      .bit_tick  (tx_bit_tick)
   );

   // Frame is stop, data LSB first, start
   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         tx_shift <= '1;
         tx_cnt   <= '0;
         tx_busy  <= 1'b0;
      end
      else if (tx_load)
      begin
         tx_shift <= {1'b1, wdata[7:0], 1'b0};
         tx_cnt   <= 4'd10;
         tx_busy  <= 1'b1;
      end
      else if (tx_busy && tx_bit_tick)
      begin
         tx_shift <= {1'b1, tx_shift[9:1]};
         tx_cnt   <= tx_cnt - 1'b1;
         if (tx_cnt == 4'd1)
            tx_busy <= 1'b0;
      end
   end

   // Line idles high from the all-ones shifter
   assign txd = tx_shift[0];

   // Two flops to settle, third for edge
   always_ff @(posedge clk)
   begin
      if (!reset_b)
         rxd_sync <= '1;
      else
         rxd_sync <= {rxd_sync[1:0], rxd};
   end

   assign start_edge = rxd_sync[2] & ~rxd_sync[1];
   assign rx_restart = start_edge & ~rx_busy;

   baud_timer i_rx_timer (
      .clk       (clk),
      .reset_b   (reset_b),
      .restart   (rx_restart),
      .half_tick (rx_half_tick),
      .bit_tick  ()
   );

   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         rx_busy  <= 1'b0;
         rx_bit   <= '0;
         rx_valid <= 1'b0;
      end
      else
      begin
         // Data read acknowledges the byte
         if (rd && a0)
            rx_valid <= 1'b0;
         if (rx_restart)
         begin
            rx_busy <= 1'b1;
            rx_bit  <= '0;
         end
         else if (rx_busy && rx_half_tick)
         begin
            if (rx_bit == 4'd0 && rxd_sync[1])
               // Glitch, not a real start bit
               rx_busy <= 1'b0;
            else if (rx_bit == 4'd9)
            begin
               rx_busy  <= 1'b0;
               rx_valid <= 1'b1;
            end
            else
               rx_bit <= rx_bit + 1'b1;
         end
      end
   end

   // Sample data bits at their centres
   always_ff @(posedge clk)
   begin
      if (rx_busy && rx_half_tick)
      begin
         if (rx_bit >= 4'd1 && rx_bit <= 4'd8)
            rx_shift <= {rxd_sync[1], rx_shift[7:1]};
         if (rx_bit == 4'd9)
            rx_data <= rx_shift;
      end
   end

   // Status at a0 low, data at a0 high
   always_ff @(posedge clk)
   begin
      if (rd)
         rdata <= a0 ? {8'h00, rx_data} : {14'h0000, rx_valid, tx_busy};
   end

endmodule

/* verilog/sram_port.sv */
// External asynchronous SRAM driver with registered controls and tristate data bus
module sram_port (
   input  logic                    clk,
   input  logic                    reset_b,
   input  system_pkg::target_sel_t sel,
   input  logic [1:0]              sram_phase,
   input  logic [17:0]             address,
   input  logic                    rnw,
   input  logic [15:0]             wdata,
   output logic [15:0]             rdata,
   output logic                    RAMWE_b,
   output logic                    RAMOE_b,
   output logic                    RAMCS_b,
   output logic [17:0]             ADR,
   inout  wire  [15:0]             DAT
);
   import system_pkg::*;

   logic        access;
   logic        drive;
   logic [15:0] dout;

   assign access = sel.sram & sel.strobe;

   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         RAMCS_b <= 1'b1;
         RAMOE_b <= 1'b1;
         RAMWE_b <= 1'b1;
         drive   <= 1'b0;
      end
      else if (access)
      begin
         RAMCS_b <= 1'b0;
         // Writes drive the bus from setup through hold
         drive   <= ~rnw;
         case (sram_phase)
            SRAM_PULSE:
            begin
               RAMOE_b <= ~rnw;
               RAMWE_b <= rnw;
            end
            SRAM_HOLD:
            begin
               // WE rises with data still driven
               RAMOE_b <= ~rnw;
               RAMWE_b <= 1'b1;
            end
            default:
            begin
               RAMOE_b <= 1'b1;
               RAMWE_b <= 1'b1;
            end
         endcase
      end
      else
      begin
         RAMCS_b <= 1'b1;
         RAMOE_b <= 1'b1;
         RAMWE_b <= 1'b1;
         drive   <= 1'b0;
      end
   end

   // Address and write data fixed at setup
   always_ff @(posedge clk)
   begin
      if (access && sram_phase == SRAM_SETUP)
      begin
         ADR  <= address;
         dout <= wdata;
      end
      // OE has been low a full cycle
      if (access && sram_phase == SRAM_HOLD && rnw)
         rdata <= DAT;
   end

   assign DAT = drive ? dout : 16'hzzzz;

endmodule

/* verilog/system.sv */
// Bus subsystem top level joining the controller, block RAM, UART and SRAM port
`include "system_settings.svh"

module system (
   input  logic                 clk,
   input  logic                 reset_b,
   input  logic                 req,
   input  system_pkg::bus_req_t bus_req,
   input  logic                 rxd,
   output logic                 ack,
   output system_pkg::bus_rsp_t bus_rsp,
   output logic                 txd,
   output logic                 RAMWE_b,
   output logic                 RAMOE_b,
   output logic                 RAMCS_b,
   output logic [17:0]          ADR,
   inout  wire  [15:0]          DAT
);
   import system_pkg::*;

   bus_req_t    req_q;
   target_sel_t sel;
   logic [1:0]  sram_phase;
   logic [31:0] ram_rdata;
   logic [15:0] uart_rdata;
   logic [15:0] sram_rdata;

   bus_cycle_ctrl i_ctrl (
      .clk        (clk),
      .reset_b    (reset_b),
      .req        (req),
      .bus_req    (bus_req),
      .ram_rdata  (ram_rdata),
      .uart_rdata (uart_rdata),
      .sram_rdata (sram_rdata),
      .ack        (ack),
      .bus_rsp    (bus_rsp),
      .sel        (sel),
      .req_q      (req_q),
      .sram_phase (sram_phase)
   );

   // Low address bits only, mirroring comes from the decode
   block_ram i_ram (
      .clk     (clk),
      .sel     (sel),
      .address (req_q.address[`RAMSIZE-1:0]),
      .rnw     (req_q.rnw),
      .wdata   (req_q.wdata),
      .rdata   (ram_rdata)
   );

   uart_port i_uart (
      .clk     (clk),
      .reset_b (reset_b),
      .sel     (sel),
      .a0      (req_q.address[0]),
      .rnw     (req_q.rnw),
      .wdata   (req_q.wdata[15:0]),
      .rxd     (rxd),
      .rdata   (uart_rdata),
      .txd     (txd)
   );

   // 16-bit external device on the low half
   sram_port i_sram (
      .clk        (clk),
      .reset_b    (reset_b),
      .sel        (sel),
      .sram_phase (sram_phase),
      .address    (req_q.address[17:0]),
      .rnw        (req_q.rnw),
      .wdata      (req_q.wdata[15:0]),
      .rdata      (sram_rdata),
      .RAMWE_b    (RAMWE_b),
      .RAMOE_b    (RAMOE_b),
      .RAMCS_b    (RAMCS_b),
      .ADR        (ADR),
      .DAT        (DAT)
   );

endmodule

/* test/system_tb.sv */
// Testbench for the bus subsystem with random traffic, SRAM pin model and UART loopback
`include "system_settings.svh"

module system_tb;
   import system_pkg::*;

   localparam int N_RAM       = 48;
   localparam int N_SRAM      = 48;
   localparam int N_HS        = 24;
   localparam int N_TRANSFERS = 1 + 2 * N_RAM + 2 * N_SRAM + 2 * N_HS + 8;
   localparam int UART_FRAMES = 3;
   localparam int ACK_LIMIT   = 20;
   localparam int WATCHDOG    = (N_TRANSFERS * 20 + UART_FRAMES * 12 * `BIT_CYCLES) * 3 / 2 + 1000;

   logic        clk;
   logic        reset_b;
   logic        req;
   bus_req_t    bus_req;
   logic        rxd;
   logic        ack;
   bus_rsp_t    bus_rsp;
   logic        txd;
   logic        RAMWE_b;
   logic        RAMOE_b;
   logic        RAMCS_b;
   logic [17:0] ADR;
   wire  [15:0] DAT;

   logic [15:0] sram_mem [0:(2**18)-1];
   logic [31:0] model [logic [19:0]];
   logic [31:0] rng_state;
   logic [31:0] got;
   logic [31:0] r;
   logic [7:0]  first;
   int          lat;
   int          sent_at;
   int          errors;
   int          tests_run;
   int          tests_failed;
   int          start_errors;
   int          cycle_count;
   string       test_name;

   system i_dut (
      .clk     (clk),
      .reset_b (reset_b),
      .req     (req),
      .bus_req (bus_req),
      .rxd     (rxd),
      .ack     (ack),
      .bus_rsp (bus_rsp),
      .txd     (txd),
      .RAMWE_b (RAMWE_b),
      .RAMOE_b (RAMOE_b),
      .RAMCS_b (RAMCS_b),
      .ADR     (ADR),
      .DAT     (DAT)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      // Serial loopback
      rxd <= txd;
   end

   // External SRAM drives only with OE and CS low
   assign DAT = (RAMOE_b === 1'b0 && RAMCS_b === 1'b0) ? sram_mem[ADR] : 16'hzzzz;

   // Write lands on the rising WE edge
   always @(posedge RAMWE_b)
   begin
      if (RAMCS_b === 1'b0)
         sram_mem[ADR] = DAT;
   end

   // Any DUT driver during OE shows up as a corrupted bus value
   always @(negedge clk)
   begin
      if (reset_b === 1'b1 && RAMOE_b === 1'b0)
         assert (DAT === sram_mem[ADR] && RAMWE_b === 1'b1)
         else
         begin
            $display("SRAM bus conflict: DUT drove DAT while OE was low at %h", ADR);
            errors++;
         end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   // Address map from the decode rules
   function automatic logic hits_uart(input logic [19:0] a);
      return (a[15:0] == `UART_BASE) || (a[15:0] == `UART_BASE + 16'd1);
   endfunction

   function automatic logic hits_ram(input logic [19:0] a);
      return (a[15:`RAMSIZE] == '0) || (&a[15:`RAMSIZE]);
   endfunction

   // RAM keyed by word offset and SRAM by its 18 pin bits
   function automatic logic [19:0] model_key(input logic [19:0] a);
      if (hits_ram(a))
         return {2'b01, 18'(a[`RAMSIZE-1:0])};
      return {2'b10, a[17:0]};
   endfunction

   // Same location seen through a random mirror or page
   function automatic logic [19:0] mirror_of(input logic [19:0] a);
      logic [31:0] x;
      logic [19:0] m;
      x = next_rand();
      if (!hits_ram(a))
         return {x[19:18], a[17:0]};
      m = {x[19:16], {(16 - `RAMSIZE){x[0]}}, a[`RAMSIZE-1:0]};
      // Top mirror overlaps the UART pair
      if (hits_uart(m))
         m[15:`RAMSIZE] = '0;
      return m;
   endfunction

   function automatic logic [19:0] random_address(input logic to_sram);
      logic [31:0] x;
      x = next_rand();
      if (!to_sram)
         return mirror_of({8'h00, x[`RAMSIZE-1:0]});
      // Flip out of the RAM and UART zones
      if (hits_ram(x[19:0]) || hits_uart(x[19:0]))
         x[15] = ~x[15];
      return x[19:0];
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic complain(input logic ok, input string what);
      assert (ok)
      else
      begin
         $display("%s: %s", test_name, what);
         errors++;
      end
   endtask

   // One four-phase cycle where hold keeps req high after ack
   task automatic bus_transfer(input logic [19:0] address, input logic rnw,
                               input logic [31:0] wdata, input int hold, input int quiet,
                               output logic [31:0] rdata, output int latency);
      repeat (next_rand() % 4) @(posedge clk);
      @(posedge clk);
      req             <= 1'b1;
      bus_req.address <= address;
      bus_req.rnw     <= rnw;
      bus_req.wdata   <= wdata;
      // DUT samples req here
      @(posedge clk);
      latency = 0;
      @(negedge clk);
      while (!ack && latency < ACK_LIMIT)
      begin
         @(posedge clk);
         latency++;
         @(negedge clk);
      end
      rdata = bus_rsp.rdata;
      complain(ack === 1'b1, "ack never rose after req");
      repeat (hold)
      begin
         @(posedge clk);
         @(negedge clk);
         complain(ack === 1'b1, "ack dropped while req was still high");
         check_value("held rdata", rdata, bus_rsp.rdata);
      end
      @(posedge clk);
      req <= 1'b0;
      @(negedge clk);
      complain(ack === 1'b1, "ack fell before req was sampled low");
      @(posedge clk);
      @(negedge clk);
      complain(ack === 1'b0, "ack did not fall one cycle after req");
      repeat (quiet)
      begin
         @(posedge clk);
         @(negedge clk);
         complain(ack === 1'b0, "a second transfer started with req low");
      end
   endtask

   // Writes then reads back through other mirrors
   task automatic random_traffic(input logic to_sram, input int count, input int max_hold,
                                 input int quiet);
      logic [19:0] written [$];
      logic [19:0] a;
      logic [31:0] d;
      logic [31:0] rd;
      int          n;
      int          expected_lat;
      expected_lat = to_sram ? 4 : 2;
      for (int i = 0; i < count; i++)
      begin
         a = random_address(to_sram);
         d = next_rand();
         bus_transfer(a, 1'b0, d, next_rand() % max_hold, quiet, rd, n);
         check_value("write ack latency", expected_lat, n);
         model[model_key(a)] = to_sram ? {16'h0000, d[15:0]} : d;
         written.push_back(a);
      end
      for (int i = 0; i < count; i++)
      begin
         a = mirror_of(written[next_rand() % written.size()]);
         bus_transfer(a, 1'b1, 32'h0, next_rand() % max_hold, quiet, rd, n);
         check_value("read ack latency", expected_lat, n);
         check_value("read data", model[model_key(a)], rd);
      end
   endtask

   task automatic begin_test(input string name);
      test_name    = name;
      start_errors = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == start_errors)
         $display("%s: passed", test_name);
      else
      begin
         tests_failed++;
         $display("%s: failed with %0d errors", test_name, errors - start_errors);
      end
   endtask

   initial
   begin
      repeat (WATCHDOG) @(posedge clk);
      $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG);
      $display("Errors found");
      $finish;
   end

   initial
   begin
      reset_b      = 1'b0;
      req          = 1'b0;
      bus_req      = '0;
      rxd          = 1'b1;
      rng_state    = 32'h746b_871a;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      cycle_count  = 0;
      repeat (16) @(posedge clk);
      reset_b <= 1'b1;

      begin_test("reset state");
      @(negedge clk);
      check_value("ack", 0, ack);
      check_value("txd", 1, txd);
      check_value("SRAM controls", 3'b111, {RAMWE_b, RAMOE_b, RAMCS_b});
      complain(DAT === 16'hzzzz, "DAT is driven after reset");
      bus_transfer({4'h0, `UART_BASE}, 1'b1, 32'h0, 0, 0, got, lat);
      check_value("UART status ack latency", 2, lat);
      check_value("UART status", 0, got);
      end_test();

      begin_test("RAM mirroring");
      random_traffic(1'b0, N_RAM, 3, 0);
      end_test();

      begin_test("external SRAM");
      random_traffic(1'b1, N_SRAM, 3, 0);
      end_test();

      begin_test("handshake delay");
      random_traffic(1'b0, N_HS / 2, 8, 3);
      random_traffic(1'b1, N_HS - N_HS / 2, 8, 3);
      end_test();

      begin_test("UART loopback");
      r     = next_rand();
      first = r[7:0];
      bus_transfer({r[19:16], `UART_BASE + 16'd1}, 1'b0, {24'h0, first}, 0, 0, got, lat);
      sent_at = cycle_count;
      check_value("data write ack latency", 2, lat);
      bus_transfer({r[19:16], `UART_BASE}, 1'b1, 32'h0, 0, 0, got, lat);
      check_value("busy bit", 1, got[0]);
      // Dropped while the frame is in flight
      bus_transfer({4'h0, `UART_BASE + 16'd1}, 1'b0, {24'h0, first ^ (r[15:8] | 8'h01)}, 0, 0,
                   got, lat);
      got = '0;
      while (!got[1] && cycle_count - sent_at < 12 * `BIT_CYCLES)
         bus_transfer({4'h0, `UART_BASE}, 1'b1, 32'h0, 0, 0, got, lat);
      complain(got[1] === 1'b1, "receive valid never set after the frame");
      check_value("cycles to valid within limit", 1, cycle_count - sent_at <= 11 * `BIT_CYCLES);
      bus_transfer({4'h0, `UART_BASE + 16'd1}, 1'b1, 32'h0, 0, 0, got, lat);
      check_value("data read ack latency", 2, lat);
      check_value("received byte", {24'h0, first}, got);
      bus_transfer({4'h0, `UART_BASE}, 1'b1, 32'h0, 0, 0, got, lat);
      check_value("valid bit after data read", 0, got[1]);
      // Wait out the stop bit and leave room for a stray second frame
      while (got[0] && cycle_count - sent_at < 14 * `BIT_CYCLES)
         bus_transfer({4'h0, `UART_BASE}, 1'b1, 32'h0, 0, 0, got, lat);
      repeat (12 * `BIT_CYCLES) @(posedge clk);
      bus_transfer({4'h0, `UART_BASE}, 1'b1, 32'h0, 0, 0, got, lat);
      check_value("status after idle line", 0, got);
      end_test();

      $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+verilog
verilog/system_pkg.sv
verilog/bus_cycle_ctrl.sv
verilog/baud_timer.sv
verilog/block_ram.sv
verilog/uart_port.sv
verilog/sram_port.sv
verilog/system.sv
test/system_tb.sv
